// ==== src/rv_exec_settings.svh ====
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// Datapath width of the execute stage, also the address width
`define RV_XLEN 32

// Shift amount comes from the low bits of operand B
`define RV_SHAMT_W 5

// Operation code width
// Bit 4 marks a branch compare, bits 3..0 follow funct3 and funct7[5]
`define RV_OP_W 5

`endif

// ==== src/rv_exec_pkg.sv ====
`default_nettype none

`include "rv_exec_settings.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0]    xlen_t;
    typedef logic [`RV_SHAMT_W-1:0] shamt_t;
    typedef logic [`RV_OP_W-1:0]    alu_op_t;

    localparam alu_op_t op_add  = 5'b00000;
    localparam alu_op_t op_sub  = 5'b01000;
    localparam alu_op_t op_sll  = 5'b00001;
    localparam alu_op_t op_srl  = 5'b00101;
    localparam alu_op_t op_sra  = 5'b01101;
    localparam alu_op_t op_slt  = 5'b00010;
    localparam alu_op_t op_sltu = 5'b00011;
    localparam alu_op_t op_xor  = 5'b00100;
    localparam alu_op_t op_or   = 5'b00110;
    localparam alu_op_t op_and  = 5'b00111;
    localparam alu_op_t op_beq  = 5'b10000;
    localparam alu_op_t op_bne  = 5'b10001;
    localparam alu_op_t op_blt  = 5'b10100;
    localparam alu_op_t op_bge  = 5'b10101;
    localparam alu_op_t op_bltu = 5'b10110;
    localparam alu_op_t op_bgeu = 5'b10111;

    typedef enum logic [1:0] {
        st_idle,   // Waiting for the ALU to start
        st_wait,   // ALU busy pulse seen
        st_report  // Report valid, done high
    } commit_state_t;

endpackage

`default_nettype wire

// ==== src/rv_adder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_exec_settings.svh"

module rv_adder import rv_exec_pkg::*; (
    input  xlen_t prop,     // a ^ b per bit
    input  xlen_t gen,      // a & b per bit
    input  logic  carry_in,
    output xlen_t sum
);

    logic [`RV_XLEN:0] carry;

    // Ripple the carry from bit 0 upwards
    always_comb begin
        carry[0] = carry_in;
        for (int i = 0; i < `RV_XLEN; i++) begin
            carry[i+1] = gen[i] | (prop[i] & carry[i]);
        end
    end

    assign sum = prop ^ carry[`RV_XLEN-1:0]; // Carry out of the top bit is dropped

endmodule

`default_nettype wire

// ==== src/rv_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_exec_settings.svh"

module rv_alu import rv_exec_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    available, // Operands held while high
    input  alu_op_t op,
    input  xlen_t   in_a,
    input  xlen_t   in_b,
    output xlen_t   out,
    output logic    busy,      // One-cycle pulse after start
    output logic    fault      // Invalid code, valid while available
);

    logic   started;
    logic   op_invalid;
    logic   sub_mode;
    logic   shift_right;
    logic   shift_fill;
    shamt_t shamt;
    xlen_t  xor_result;
    xlen_t  or_result;
    xlen_t  and_result;
    xlen_t  adder_b;
    xlen_t  adder_sum;
    xlen_t  shift_in;
    xlen_t  shift_stage;
    xlen_t  shift_result;
    logic   cmp_unsigned;
    logic   cmp_lt;
    logic   a_eq_b;
    logic   cmp_bit;
    xlen_t  op_result;

    // Anything outside the RV32I subset raises fault
    always_comb begin
        case (op)
            op_add, op_sub, op_sll, op_srl, op_sra, op_slt, op_sltu,
            op_xor, op_or, op_and, op_beq, op_bne, op_blt, op_bge,
            op_bltu, op_bgeu: op_invalid = 1'b0;
            default:          op_invalid = 1'b1;
        endcase
    end

    assign sub_mode    = (op != op_add);        // SUB and every compare subtract
    assign shift_right = op[2];
    assign shift_fill  = op[3] & op[2] & in_a[`RV_XLEN-1]; // SRA sign fill
    assign shamt       = in_b[`RV_SHAMT_W-1:0];

    assign xor_result = in_a ^ in_b;
    assign or_result  = in_a | in_b;
    assign and_result = in_a & in_b;

    assign adder_b = in_b ^ {`RV_XLEN{sub_mode}};

    rv_adder adder_i (
        .prop     (in_a ^ adder_b),
        .gen      (in_a & adder_b),
        .carry_in (sub_mode),
        .sum      (adder_sum)
    );

    // Right shifts reuse the left shifter on bit-reversed data
    always_comb begin
        for (int i = 0; i < `RV_XLEN; i++) begin
            shift_in[i] = shift_right ? in_a[`RV_XLEN-1-i] : in_a[i];
        end
        shift_stage = shift_in;
        for (int s = `RV_SHAMT_W-1; s >= 0; s--) begin
            if (shamt[s]) begin
                shift_stage = (shift_stage << (1 << s))
                            | ({`RV_XLEN{shift_fill}} & ~({`RV_XLEN{1'b1}} << (1 << s)));
            end
        end
        for (int i = 0; i < `RV_XLEN; i++) begin
            shift_result[i] = shift_right ? shift_stage[`RV_XLEN-1-i] : shift_stage[i];
        end
    end

    // Signs differ, so the difference sign cannot be trusted
    assign cmp_unsigned = op[4] ? op[1] : op[0];  // BLTU/BGEU or SLTU
    assign cmp_lt = (in_a[`RV_XLEN-1] ^ in_b[`RV_XLEN-1])
                  ? (cmp_unsigned ? in_b[`RV_XLEN-1] : in_a[`RV_XLEN-1])
                  : adder_sum[`RV_XLEN-1];
    assign a_eq_b  = (xor_result == '0);
    assign cmp_bit = ((op[4] & ~op[2]) ? a_eq_b : cmp_lt) ^ (op[4] & op[0]); // BNE/BGE/BGEU

    always_comb begin
        case (op)
            op_add, op_sub:         op_result = adder_sum;
            op_sll, op_srl, op_sra: op_result = shift_result;
            op_xor:                 op_result = xor_result;
            op_or:                  op_result = or_result;
            op_and:                 op_result = and_result;
            default:                op_result = {{(`RV_XLEN-1){1'b0}}, cmp_bit};
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
            busy    <= 1'b0;
            fault   <= 1'b0;
        end else begin
            started <= available;
            busy    <= available & ~started;  // High only in the first cycle
            fault   <= available & op_invalid;
        end
    end

    always_ff @(posedge clk) begin
        if (busy & started) begin
            out <= op_result;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_branch_target.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_branch_target import rv_exec_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  available,
    input  xlen_t pc,
    input  xlen_t imm,          // Sign-extended branch offset
    output xlen_t target_pc,
    output xlen_t next_seq_pc
);

    localparam xlen_t seq_step = xlen_t'(4); // One instruction word

    logic  started;
    xlen_t target_sum;
    xlen_t seq_sum;

    rv_adder target_adder_i (
        .prop     (pc ^ imm),
        .gen      (pc & imm),
        .carry_in (1'b0),
        .sum      (target_sum)
    );

    rv_adder seq_adder_i (
        .prop     (pc ^ seq_step),
        .gen      (pc & seq_step),
        .carry_in (1'b0),
        .sum      (seq_sum)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
        end else begin
            started <= available;
        end
    end

    // Capture on the start edge and hold through the ALU operation
    always_ff @(posedge clk) begin
        if (available & ~started) begin
            target_pc   <= target_sum;
            next_seq_pc <= seq_sum;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_exec_commit.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_exec_commit import rv_exec_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  alu_busy,
    input  xlen_t alu_result,
    input  logic  alu_fault,
    input  logic  is_branch,    // Op bit 4
    input  xlen_t target_pc,
    input  xlen_t next_seq_pc,
    output logic  done,
    output xlen_t rd_data,
    output logic  rd_write,
    output xlen_t next_pc,
    output logic  branch_taken,
    output logic  fault
);

    commit_state_t state;
    logic          report_load;
    logic          taken;

    assign report_load = (state == st_wait) & ~alu_busy; // ALU result now stable
    assign taken       = is_branch & ~alu_fault & alu_result[0];
    assign done        = (state == st_report);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (alu_busy) state <= st_wait;
                st_wait:   if (!alu_busy) state <= st_report;
                st_report: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    // Report is held until the next operation completes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data      <= '0;
            rd_write     <= 1'b0;
            next_pc      <= '0;
            branch_taken <= 1'b0;
            fault        <= 1'b0;
        end else if (report_load) begin
            fault        <= alu_fault;
            branch_taken <= taken;
            rd_write     <= ~alu_fault & ~is_branch;
            rd_data      <= (alu_fault | is_branch) ? '0 : alu_result;
            next_pc      <= taken ? target_pc : next_seq_pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv_exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_exec_settings.svh"

module rv_exec_top import rv_exec_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    available,
    input  alu_op_t op,
    input  xlen_t   in_a,
    input  xlen_t   in_b,
    input  xlen_t   pc,
    input  xlen_t   imm,
    output logic    done,
    output xlen_t   rd_data,
    output logic    rd_write,
    output xlen_t   next_pc,
    output logic    branch_taken,
    output logic    fault
);

    xlen_t alu_result;
    logic  alu_busy;
    logic  alu_fault;
    xlen_t target_pc;
    xlen_t next_seq_pc;

    rv_alu alu_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .available (available),
        .op        (op),
        .in_a      (in_a),
        .in_b      (in_b),
        .out       (alu_result),
        .busy      (alu_busy),
        .fault     (alu_fault)
    );

    rv_branch_target branch_target_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .available   (available),
        .pc          (pc),
        .imm         (imm),
        .target_pc   (target_pc),
        .next_seq_pc (next_seq_pc)
    );

    rv_exec_commit commit_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .alu_busy     (alu_busy),
        .alu_result   (alu_result),
        .alu_fault    (alu_fault),
        .is_branch    (op[`RV_OP_W-1]),  // Branch marker bit
        .target_pc    (target_pc),
        .next_seq_pc  (next_seq_pc),
        .done         (done),
        .rd_data      (rd_data),
        .rd_write     (rd_write),
        .next_pc      (next_pc),
        .branch_taken (branch_taken),
        .fault        (fault)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 10, // 20 ns clock
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a rising edge so the first active cycle is a full one
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/rv_exec_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv_exec_settings.svh"

module rv_exec_checker import rv_exec_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    available,
    input  alu_op_t op,
    input  xlen_t   in_a,
    input  xlen_t   in_b,
    input  xlen_t   pc,
    input  xlen_t   imm,
    input  logic    done,
    input  xlen_t   rd_data,
    input  logic    rd_write,
    input  xlen_t   next_pc,
    input  logic    branch_taken,
    input  logic    fault,
    output int      pass_count,
    output int      fail_count
);

    logic    prev_avail;
    logic    pending;     // Operation started, done not yet seen
    logic    reset_seen;
    logic    test_bad;
    int      edge_count;
    int      test_num;
    alu_op_t cap_op;
    xlen_t   cap_a;
    xlen_t   cap_b;
    xlen_t   cap_pc;
    xlen_t   cap_imm;
    xlen_t   exp_data;
    xlen_t   exp_pc;
    logic    exp_write;
    logic    exp_taken;
    logic    exp_fault;

    initial begin
        pass_count = 0;
        fail_count = 0;
        test_num   = 0;
        prev_avail = 1'b0;
        pending    = 1'b0;
        reset_seen = 1'b0;
    end

    task automatic compare_field(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, expected, actual);
            test_bad = 1'b1;
        end
    endtask

    task automatic count_result(input string label);
        if (test_bad) begin
            fail_count++;
            $display("%s: mismatch", label);
        end else begin
            pass_count++;
            $display("%s: ok", label);
        end
    endtask

    // Reference model of the RV32I compare and ALU rules
    task automatic predict_report();
        shamt_t sh;
        xlen_t  res;
        logic   valid;
        logic   take;
        sh    = cap_b[`RV_SHAMT_W-1:0];
        res   = '0;
        valid = 1'b1;
        take  = 1'b0;
        case (cap_op)
            5'b00000: res = cap_a + cap_b;
            5'b01000: res = cap_a - cap_b;
            5'b00001: res = cap_a << sh;
            5'b00101: res = cap_a >> sh;
            5'b01101: res = $signed(cap_a) >>> sh;
            5'b00010: res = xlen_t'($signed(cap_a) < $signed(cap_b));
            5'b00011: res = xlen_t'(cap_a < cap_b);
            5'b00100: res = cap_a ^ cap_b;
            5'b00110: res = cap_a | cap_b;
            5'b00111: res = cap_a & cap_b;
            5'b10000: take = (cap_a == cap_b);
            5'b10001: take = (cap_a != cap_b);
            5'b10100: take = ($signed(cap_a) < $signed(cap_b));
            5'b10101: take = ($signed(cap_a) >= $signed(cap_b));
            5'b10110: take = (cap_a < cap_b);
            5'b10111: take = (cap_a >= cap_b);
            default:  valid = 1'b0;
        endcase
        exp_fault = ~valid;
        exp_taken = valid & cap_op[4] & take;
        exp_write = valid & ~cap_op[4];
        exp_data  = exp_write ? res : '0;
        exp_pc    = exp_taken ? cap_pc + cap_imm : cap_pc + 32'd4;
    endtask

    task automatic check_report();
        predict_report();
        if (edge_count != 3) begin
            $display("Test %0d: done came %0d edges after start instead of 3",
                     test_num, edge_count);
            test_bad = 1'b1;
        end
        if (!exp_fault) begin
            compare_field("rd_data", exp_data, rd_data); // Not defined on a fault
        end
        compare_field("rd_write", exp_write, rd_write);
        compare_field("next_pc", exp_pc, next_pc);
        compare_field("branch_taken", exp_taken, branch_taken);
        compare_field("fault", exp_fault, fault);
        count_result($sformatf("Test %0d op %05b a 0x%h b 0x%h", test_num, cap_op, cap_a, cap_b));
        test_num++;
        pending = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            prev_avail = 1'b0;
            pending    = 1'b0;
            reset_seen = 1'b0;
        end else begin
            if (!reset_seen) begin
                test_bad = 1'b0;
                compare_field("done", 1'b0, done);
                compare_field("rd_data", '0, rd_data);
                compare_field("rd_write", 1'b0, rd_write);
                compare_field("next_pc", '0, next_pc);
                compare_field("branch_taken", 1'b0, branch_taken);
                compare_field("fault", 1'b0, fault);
                count_result("Reset values");
                reset_seen = 1'b1;
            end
            if (available && !prev_avail) begin
                if (pending) begin
                    $display("Test %0d: available rose again before done", test_num);
                    fail_count++;
                end
                cap_op     = op;
                cap_a      = in_a;
                cap_b      = in_b;
                cap_pc     = pc;
                cap_imm    = imm;
                pending    = 1'b1;
                edge_count = 0;     // This edge is E0
                test_bad   = 1'b0;
            end else if (pending) begin
                edge_count++;
            end
            if (done) begin
                if (pending) begin
                    check_report();
                end else begin
                    $display("Test %0d: done pulsed with no operation in flight", test_num);
                    fail_count++;
                end
            end
            prev_avail = available;
        end
    end

endmodule

`default_nettype wire

// ==== dv/rv_exec_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_exec_tb import rv_exec_pkg::*; ();

    localparam int reset_cycles = 5;

    logic    clk;
    logic    arst_n;
    logic    available;
    alu_op_t op;
    xlen_t   in_a;
    xlen_t   in_b;
    xlen_t   pc;
    xlen_t   imm;
    logic    done;
    xlen_t   rd_data;
    logic    rd_write;
    xlen_t   next_pc;
    logic    branch_taken;
    logic    fault;
    int      pass_count;
    int      fail_count;
    logic    table_ready = 1'b0;

    // Stimulus table, one entry per operation
    alu_op_t tbl_op[$];
    xlen_t   tbl_a[$];
    xlen_t   tbl_b[$];
    xlen_t   tbl_pc[$];
    xlen_t   tbl_imm[$];
    logic    tbl_rnd[$];   // Operands A and B drawn at random

    tb_clock_gen #(.reset_cycles(reset_cycles)) clock_gen_i (.clk(clk), .arst_n(arst_n));

    rv_exec_top dut_i (
        .clk (clk), .arst_n (arst_n), .available (available), .op (op),
        .in_a (in_a), .in_b (in_b), .pc (pc), .imm (imm),
        .done (done), .rd_data (rd_data), .rd_write (rd_write), .next_pc (next_pc),
        .branch_taken (branch_taken), .fault (fault)
    );

    rv_exec_checker checker_i (
        .clk (clk), .arst_n (arst_n), .available (available), .op (op),
        .in_a (in_a), .in_b (in_b), .pc (pc), .imm (imm),
        .done (done), .rd_data (rd_data), .rd_write (rd_write), .next_pc (next_pc),
        .branch_taken (branch_taken), .fault (fault),
        .pass_count (pass_count), .fail_count (fail_count)
    );

    task automatic add_entry(input alu_op_t o, input xlen_t a, input xlen_t b,
                             input xlen_t p, input xlen_t i, input logic rnd);
        tbl_op.push_back(o);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_pc.push_back(p);
        tbl_imm.push_back(i);
        tbl_rnd.push_back(rnd);
    endtask

    task automatic load_table();
        add_entry(op_add,  32'h7fff_ffff, 32'h0000_0001, 32'h0000_1000, 32'h0, 0);
        add_entry(op_add,  32'hffff_ffff, 32'h0000_0001, 32'h0000_1004, 32'h0, 0);
        add_entry(op_add,  32'h0,         32'h0,         32'h0000_1008, 32'h0, 1);
        add_entry(op_sub,  32'h0000_0000, 32'h0000_0001, 32'h0000_100c, 32'h0, 0);
        add_entry(op_sub,  32'h0,         32'h0,         32'h0000_1010, 32'h0, 1);
        add_entry(op_xor,  32'ha5a5_a5a5, 32'hffff_0000, 32'h0000_1014, 32'h0, 0);
        add_entry(op_xor,  32'h0,         32'h0,         32'h0000_1014, 32'h0, 1);
        add_entry(op_or,   32'hf0f0_f0f0, 32'h0f0f_0000, 32'h0000_1018, 32'h0, 0);
        add_entry(op_or,   32'h0,         32'h0,         32'h0000_1018, 32'h0, 1);
        add_entry(op_and,  32'hffff_0000, 32'h0ff0_0ff0, 32'h0000_101c, 32'h0, 0);
        add_entry(op_and,  32'h0,         32'h0,         32'h0000_101c, 32'h0, 1);
        add_entry(op_sll,  32'h1234_5678, 32'h0000_0000, 32'h0000_1020, 32'h0, 0);
        add_entry(op_sll,  32'h8000_0001, 32'h0000_0001, 32'h0000_1020, 32'h0, 0);
        add_entry(op_sll,  32'h8000_0001, 32'h0000_001f, 32'h0000_1024, 32'h0, 0);
        add_entry(op_sll,  32'h0,         32'h0,         32'h0000_1028, 32'h0, 1);
        add_entry(op_srl,  32'h8000_0001, 32'h0000_0000, 32'h0000_102c, 32'h0, 0);
        add_entry(op_srl,  32'h8000_0001, 32'h0000_0001, 32'h0000_102c, 32'h0, 0);
        add_entry(op_srl,  32'h8000_0001, 32'h0000_001f, 32'h0000_102c, 32'h0, 0);
        add_entry(op_srl,  32'h0,         32'h0,         32'h0000_1030, 32'h0, 1);
        add_entry(op_sra,  32'h8000_0001, 32'h0000_0000, 32'h0000_1034, 32'h0, 0);
        add_entry(op_sra,  32'h8000_0001, 32'h0000_0001, 32'h0000_1034, 32'h0, 0);
        add_entry(op_sra,  32'h8000_0000, 32'h0000_001f, 32'h0000_1034, 32'h0, 0);
        add_entry(op_sra,  32'hf000_0000, 32'h0000_0024, 32'h0000_1038, 32'h0, 0); // Upper B bits
        add_entry(op_sra,  32'h0,         32'h0,         32'h0000_103c, 32'h0, 1);
        add_entry(op_slt,  32'hffff_ffff, 32'h0000_0001, 32'h0000_1040, 32'h0, 0);
        add_entry(op_slt,  32'h0000_0001, 32'hffff_ffff, 32'h0000_1040, 32'h0, 0);
        add_entry(op_slt,  32'h0000_0005, 32'h0000_0005, 32'h0000_1044, 32'h0, 0);
        add_entry(op_sltu, 32'hffff_ffff, 32'h0000_0001, 32'h0000_1048, 32'h0, 0);
        add_entry(op_sltu, 32'h0000_0001, 32'hffff_ffff, 32'h0000_104c, 32'h0, 0);
        add_entry(op_sltu, 32'h0000_0005, 32'h0000_0005, 32'h0000_104c, 32'h0, 0);
        add_entry(op_beq,  32'h0000_0005, 32'h0000_0005, 32'h0000_2000, 32'h0000_0040, 0);
        add_entry(op_bne,  32'h0000_0005, 32'h0000_0005, 32'h0000_2000, 32'h0000_0040, 0);
        add_entry(op_bne,  32'h0000_0005, 32'h0000_0006, 32'h0000_2000, 32'h0000_0040, 0);
        add_entry(op_blt,  32'hffff_ffff, 32'h0000_0001, 32'h0000_2000, 32'hffff_fff0, 0);
        add_entry(op_blt,  32'h0000_0001, 32'hffff_ffff, 32'h0000_2000, 32'hffff_fff0, 0);
        add_entry(op_blt,  32'h0000_0007, 32'h0000_0007, 32'h0000_2000, 32'hffff_fff0, 0);
        add_entry(op_bge,  32'h0000_0007, 32'h0000_0007, 32'h0000_2000, 32'hffff_fff0, 0);
        add_entry(op_bge,  32'hffff_ffff, 32'h0000_0001, 32'h0000_2000, 32'h0000_0100, 0);
        add_entry(op_bltu, 32'hffff_ffff, 32'h0000_0001, 32'h0000_2000, 32'h0000_0100, 0);
        add_entry(op_bltu, 32'h0000_0001, 32'h0000_0002, 32'h0000_2000, 32'h0000_0020, 0);
        add_entry(op_bltu, 32'h0000_0007, 32'h0000_0007, 32'h0000_2000, 32'h0000_0020, 0);
        add_entry(op_bgeu, 32'hffff_ffff, 32'h0000_0001, 32'h0000_2000, 32'h0000_0020, 0);
        add_entry(op_bgeu, 32'h0000_0001, 32'hffff_ffff, 32'h0000_2000, 32'h0000_0020, 0);
        add_entry(op_bgeu, 32'h0000_0007, 32'h0000_0007, 32'h0000_2000, 32'h0000_0020, 0);
        add_entry(op_beq,  32'h0,         32'h0,         32'h0000_2000, 32'h0000_0080, 1);
        add_entry(5'b01001, 32'h0000_0003, 32'h0000_0003, 32'h0000_3000, 32'h0000_0010, 0);
        add_entry(5'b11000, 32'h0000_0003, 32'h0000_0003, 32'h0000_3004, 32'h0000_0010, 0);
        add_entry(5'b11111, 32'h0000_0003, 32'h0000_0003, 32'h0000_3008, 32'h0000_0010, 0);
    endtask

    // One operation, held until done, then two low cycles on available
    task automatic run_entry(input int idx);
        @(posedge clk);
        op        <= tbl_op[idx];
        in_a      <= tbl_rnd[idx] ? $urandom : tbl_a[idx];
        in_b      <= tbl_rnd[idx] ? $urandom : tbl_b[idx];
        pc        <= tbl_pc[idx];
        imm       <= tbl_imm[idx];
        available <= 1'b1;
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
        available <= 1'b0;
        @(posedge clk);
    endtask

    initial begin : main_seq
        int seed_value;
        available  = 1'b0;
        op         = '0;
        in_a       = '0;
        in_b       = '0;
        pc         = '0;
        imm        = '0;
        seed_value = $urandom(32'h592d0cce);
        load_table();
        table_ready = 1'b1;
        wait (arst_n === 1'b1);
        for (int i = 0; i < tbl_op.size(); i++) begin
            run_entry(i);
        end
        repeat (2) @(posedge clk);
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == tbl_op.size() + 1) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (pass_count + fail_count != tbl_op.size() + 1) begin
                $display("Checker finished %0d tests but the table holds %0d plus reset",
                         pass_count + fail_count, tbl_op.size());
            end
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (tbl_op.size() * 10 + reset_cycles) @(posedge clk);
        $display("Timeout: done never came, the run did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/rv_exec_pkg.sv
src/rv_adder.sv
src/rv_alu.sv
src/rv_branch_target.sv
src/rv_exec_commit.sv
src/rv_exec_top.sv
dv/tb_clock_gen.sv
dv/rv_exec_checker.sv
dv/rv_exec_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_exec_pkg.sv
      - src/rv_adder.sv
      - src/rv_alu.sv
      - src/rv_branch_target.sv
      - src/rv_exec_commit.sv
      - src/rv_exec_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_clock_gen.sv
      - dv/rv_exec_checker.sv
      - dv/rv_exec_tb.sv
